//--- verilog/boot_rom.hex
// Boot ROM image for $readmemh, one 32-bit word per line, word 0 first
00000297
02028293
30529073
00001137
ff010113
000102b7
00428293
0002a303
00030663
000280e7
0000006f
10500073
ffdff06f
5e5c0001
a5a5c3c3
0badf00d

//--- src.f
verilog/obi_pkg.sv
verilog/ao_periph_pkg.sv
verilog/obi_arbiter.sv
verilog/obi_to_reg.sv
verilog/reg_demux.sv
verilog/soc_ctrl.sv
verilog/boot_rom.sv
verilog/power_manager.sv
verilog/ao_timer.sv
verilog/ao_peripheral_subsystem.sv
testbench/ao_peripheral_subsystem_assert.sv
testbench/tb_ao_peripheral_subsystem.sv

//--- testbench/tb_ao_peripheral_subsystem.sv
/* Testbench for the always-on peripheral subsystem
   Random traffic from both OBI ports checked against a register model */
`timescale 1ns/1ns
`default_nettype none

module tb_ao_peripheral_subsystem
  import obi_pkg::*;
  import ao_periph_pkg::*;
();

  localparam int unsigned ROM_WORDS = 16;
  localparam int unsigned GNT_LIMIT = 16;
  localparam int unsigned RSP_LIMIT = 16;

  logic        clk_i;
  logic        rst_i;
  obi_req_t    core_req_i;
  obi_resp_t   core_resp_o;
  obi_req_t    dbg_req_i;
  obi_resp_t   dbg_resp_o;
  logic        boot_select_i;
  logic        exit_valid_o;
  logic [31:0] exit_value_o;
  logic        power_gate_core_o;
  logic        cpu_rst_o;
  logic        timer_irq_o;

  // Register model
  logic [31:0] rom_model [ROM_WORDS];
  logic        m_exit_valid;
  logic [31:0] m_exit_value;
  logic [31:0] m_scratch;
  logic [2:0]  m_pm_state;
  bit          next_dbg;

  ao_peripheral_subsystem dut0 (
    .clk_i,
    .rst_i,
    .core_req_i,
    .core_resp_o,
    .dbg_req_i,
    .dbg_resp_o,
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o,
    .power_gate_core_o,
    .cpu_rst_o,
    .timer_irq_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    stop_run();
  endtask

  task automatic verify_resp(input string name, input obi_resp_t got, input logic exp_err,
                             input logic [31:0] exp_rdata, input bit with_data);
    if (got.rvalid !== 1'b1) begin
      report_mismatch({name, " rvalid"}, 32'(got.rvalid), 32'h1);
    end
    if (got.err !== exp_err) begin
      report_mismatch({name, " err"}, 32'(got.err), 32'(exp_err));
    end
    if (with_data && got.rdata !== exp_rdata) begin
      report_mismatch({name, " rdata"}, got.rdata, exp_rdata);
    end
  endtask

  task automatic expect_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch(name, 32'(got), 32'(exp));
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      report_mismatch(name, got, exp);
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic logic [31:0] periph_addr(input logic [3:0] idx, input logic [7:0] off);
    return {20'h0, idx, off};
  endfunction

  // Even words for the core, odd words for debug
  function automatic obi_req_t rom_read_req(input bit odd);
    obi_req_t r;
    r = '0;
    r.req = 1'b1;
    r.be = 4'hF;
    r.addr = periph_addr(4'(BOOT_ROM_IDX), {2'b00, 3'($urandom_range(7, 0)), odd, 2'b00});
    return r;
  endfunction

  task automatic drive_port(input bit port, input obi_req_t r);
    if (port) begin
      dbg_req_i = r;
    end else begin
      core_req_i = r;
    end
  endtask

  task automatic bus_access(input bit port, input logic we, input logic [3:0] be,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output obi_resp_t rsp);
    obi_req_t    r;
    obi_resp_t   cur;
    int unsigned n;
    r.req = 1'b1;
    r.we = we;
    r.be = be;
    r.addr = addr;
    r.wdata = wdata;
    @(negedge clk_i);
    drive_port(port, r);
    n = 0;
    #1;
    cur = port ? dbg_resp_o : core_resp_o;
    while (!cur.gnt) begin
      if (n == GNT_LIMIT) begin
        $display("No grant on port %0d within %0d cycles", port, GNT_LIMIT);
        stop_run();
      end
      n++;
      @(negedge clk_i);
      #1;
      cur = port ? dbg_resp_o : core_resp_o;
    end
    next_dbg = ~port;
    @(negedge clk_i);
    drive_port(port, '0);
    n = 0;
    cur = port ? dbg_resp_o : core_resp_o;
    while (!cur.rvalid) begin
      if (n == RSP_LIMIT) begin
        $display("No response on port %0d within %0d cycles", port, RSP_LIMIT);
        stop_run();
      end
      n++;
      @(negedge clk_i);
      cur = port ? dbg_resp_o : core_resp_o;
    end
    rsp = cur;
  endtask

  task automatic write_word(input bit port, input logic [31:0] addr, input logic [31:0] data);
    obi_resp_t rsp;
    bus_access(port, 1'b1, 4'hF, addr, data, rsp);
    verify_resp("register write", rsp, 1'b0, '0, 1'b0);
  endtask

  task automatic read_expect(input bit port, input logic [31:0] addr,
                             input logic [31:0] exp, input string name);
    obi_resp_t rsp;
    bus_access(port, 1'b0, 4'hF, addr, '0, rsp);
    verify_resp(name, rsp, 1'b0, exp, 1'b1);
  endtask

  task automatic wait_irq_level(input logic level, input int unsigned limit);
    int unsigned n;
    n = 0;
    while (timer_irq_o !== level) begin
      if (n == limit) begin
        $display("timer_irq_o did not reach %0b within %0d cycles", level, limit);
        stop_run();
      end
      n++;
      @(negedge clk_i);
    end
  endtask

  task automatic soc_traffic(input int unsigned count);
    obi_resp_t   rsp;
    logic [7:0]  off;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] exp;
    bit          port;
    bit          we;
    for (int unsigned i = 0; i < count; i++) begin
      port = 1'($urandom_range(1, 0));
      we = 1'($urandom_range(1, 0));
      be = 4'($urandom);
      wdata = $urandom;
      boot_select_i = 1'($urandom_range(1, 0));
      case ($urandom_range(3, 0))
        0: off = SOC_EXIT_VALID;
        1: off = SOC_EXIT_VALUE;
        2: off = SOC_BOOT_SELECT;
        default: off = SOC_SCRATCH;
      endcase
      bus_access(port, we, be, periph_addr(4'(SOC_CTRL_IDX), off), wdata, rsp);
      if (we) begin
        verify_resp("soc write", rsp, 1'b0, '0, 1'b0);
        if (off == SOC_EXIT_VALID && be[0]) begin
          m_exit_valid = wdata[0];
        end
        if (off == SOC_EXIT_VALUE) begin
          m_exit_value = merge_bytes(m_exit_value, wdata, be);
        end
        if (off == SOC_SCRATCH) begin
          m_scratch = merge_bytes(m_scratch, wdata, be);
        end
        @(negedge clk_i);
        expect_level("exit_valid_o", exit_valid_o, m_exit_valid);
        compare_word("exit_value_o", exit_value_o, m_exit_value);
      end else begin
        case (off)
          SOC_EXIT_VALID: exp = {31'b0, m_exit_valid};
          SOC_EXIT_VALUE: exp = m_exit_value;
          SOC_BOOT_SELECT: exp = {31'b0, boot_select_i};
          default: exp = m_scratch;
        endcase
        verify_resp("soc read", rsp, 1'b0, exp, 1'b1);
      end
    end
  endtask

  task automatic rom_traffic(input int unsigned count);
    obi_resp_t  rsp;
    logic [7:0] off;
    bit         port;
    for (int unsigned i = 0; i < count; i++) begin
      port = 1'($urandom_range(1, 0));
      // Offsets past the last word wrap around
      off = {6'($urandom_range(63, 0)), 2'b00};
      if ($urandom_range(3, 0) == 0) begin
        bus_access(port, 1'b1, 4'hF, periph_addr(4'(BOOT_ROM_IDX), off), $urandom, rsp);
        verify_resp("rom write", rsp, 1'b1, '0, 1'b0);
      end
      read_expect(port, periph_addr(4'(BOOT_ROM_IDX), off), rom_model[off[5:2]], "rom read");
    end
  endtask

  task automatic unmapped_traffic(input int unsigned count);
    obi_resp_t   rsp;
    logic [3:0]  idx;
    logic [7:0]  off;
    for (int unsigned i = 0; i < count; i++) begin
      idx = 4'($urandom_range(15, 4));
      // Offsets of live registers, so any aliasing shows up
      off = {4'h0, 2'($urandom_range(3, 0)), 2'b00};
      bus_access(1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)), 4'($urandom),
                 periph_addr(idx, off), $urandom | 32'h1, rsp);
      verify_resp("unmapped access", rsp, 1'b1, 32'h0, 1'b1);
    end
  endtask

  task automatic check_registers_kept();
    read_expect(1'b0, periph_addr(4'(SOC_CTRL_IDX), SOC_EXIT_VALID), {31'b0, m_exit_valid},
                "exit_valid read");
    read_expect(1'b1, periph_addr(4'(SOC_CTRL_IDX), SOC_EXIT_VALUE), m_exit_value,
                "exit_value read");
    read_expect(1'b0, periph_addr(4'(SOC_CTRL_IDX), SOC_SCRATCH), m_scratch, "scratch read");
    expect_level("exit_valid_o", exit_valid_o, m_exit_valid);
    compare_word("exit_value_o", exit_value_o, m_exit_value);
    read_expect(1'b1, periph_addr(4'(POWER_MANAGER_IDX), PM_STATUS), {29'b0, m_pm_state},
                "pm status read");
    // Timer still idle from reset
    read_expect(1'b0, periph_addr(4'(TIMER_IDX), TIMER_CTRL), 32'h0, "timer ctrl read");
    read_expect(1'b1, periph_addr(4'(TIMER_IDX), TIMER_COMPARE), 32'h0, "timer compare read");
    read_expect(1'b0, periph_addr(4'(TIMER_IDX), TIMER_PRESCALE), 32'h0, "timer prescale read");
    read_expect(1'b1, periph_addr(4'(TIMER_IDX), TIMER_COUNT), 32'h0, "timer count read");
    expect_level("cpu_rst_o", cpu_rst_o, 1'b0);
  endtask

  task automatic contend_rom_reads(input int unsigned rounds);
    obi_req_t    r0;
    obi_req_t    r1;
    logic [31:0] exp0;
    logic [31:0] exp1;
    int unsigned left0;
    int unsigned left1;
    int unsigned cycles;
    bit          pend0;
    bit          pend1;
    r0 = rom_read_req(1'b0);
    r1 = rom_read_req(1'b1);
    left0 = rounds;
    left1 = rounds;
    pend0 = 1'b0;
    pend1 = 1'b0;
    cycles = 0;
    while (left0 != 0 || left1 != 0 || pend0 || pend1) begin
      if (cycles == 4 * rounds + 8) begin
        $display("Contended reads did not complete within %0d cycles", cycles);
        stop_run();
      end
      cycles++;
      @(negedge clk_i);
      if (pend0) begin
        verify_resp("core contended read", core_resp_o, 1'b0, exp0, 1'b1);
      end
      if (pend1) begin
        verify_resp("dbg contended read", dbg_resp_o, 1'b0, exp1, 1'b1);
      end
      pend0 = 1'b0;
      pend1 = 1'b0;
      if (left0 != 0) begin
        core_req_i = r0;
      end else begin
        core_req_i = '0;
      end
      if (left1 != 0) begin
        dbg_req_i = r1;
      end else begin
        dbg_req_i = '0;
      end
      #1;
      // Round robin when both ask
      if (left0 != 0 && left1 != 0) begin
        expect_level("core_resp_o.gnt", core_resp_o.gnt, ~next_dbg);
        expect_level("dbg_resp_o.gnt", dbg_resp_o.gnt, next_dbg);
      end
      if (core_resp_o.gnt) begin
        exp0 = rom_model[r0.addr[5:2]];
        pend0 = 1'b1;
        left0--;
        next_dbg = 1'b1;
        r0 = rom_read_req(1'b0);
      end
      if (dbg_resp_o.gnt) begin
        exp1 = rom_model[r1.addr[5:2]];
        pend1 = 1'b1;
        left1--;
        next_dbg = 1'b0;
        r1 = rom_read_req(1'b1);
      end
    end
  endtask

  task automatic timer_sequence();
    obi_resp_t   rsp;
    logic [31:0] presc;
    logic [31:0] cmp;
    logic [31:0] last;
    presc = $urandom_range(3, 0);
    cmp = $urandom_range(12, 4);
    write_word(1'b0, periph_addr(4'(TIMER_IDX), TIMER_COUNT), 32'h0);
    write_word(1'b1, periph_addr(4'(TIMER_IDX), TIMER_PRESCALE), presc);
    write_word(1'b0, periph_addr(4'(TIMER_IDX), TIMER_COMPARE), cmp);
    write_word(1'b1, periph_addr(4'(TIMER_IDX), TIMER_CTRL), 32'h1);
    wait_irq_level(1'b1, (cmp + 1) * (presc + 1) + 16);
    // Count already past compare once irq is up
    last = cmp;
    for (int i = 0; i < 4; i++) begin
      bus_access(1'(i), 1'b0, 4'hF, periph_addr(4'(TIMER_IDX), TIMER_COUNT), '0, rsp);
      verify_resp("timer count read", rsp, 1'b0, '0, 1'b0);
      if (rsp.rdata < last) begin
        $display("FAILED at %0t ns: timer count got 0x%08h expected at least 0x%08h",
                 $time, rsp.rdata, last);
        stop_run();
      end
      last = rsp.rdata;
    end
    write_word(1'b0, periph_addr(4'(TIMER_IDX), TIMER_CTRL), 32'h0);
    wait_irq_level(1'b0, 4);
  endtask

  task automatic sleep_sequence();
    logic [31:0] cmp;
    cmp = $urandom_range(10, 4);
    write_word(1'b0, periph_addr(4'(TIMER_IDX), TIMER_COUNT), 32'h0);
    write_word(1'b0, periph_addr(4'(TIMER_IDX), TIMER_PRESCALE), 32'h0);
    write_word(1'b0, periph_addr(4'(TIMER_IDX), TIMER_COMPARE), cmp);
    write_word(1'b0, periph_addr(4'(POWER_MANAGER_IDX), PM_CTRL), 32'h1);
    m_pm_state = 3'd1;
    expect_level("cpu_rst_o", cpu_rst_o, 1'b1);
    expect_level("power_gate_core_o", power_gate_core_o, 1'b0);
    @(negedge clk_i);
    m_pm_state = 3'd2;
    expect_level("cpu_rst_o", cpu_rst_o, 1'b1);
    expect_level("power_gate_core_o", power_gate_core_o, 1'b1);
    // Second sleep request while gated
    write_word(1'b1, periph_addr(4'(POWER_MANAGER_IDX), PM_CTRL), 32'h1);
    read_expect(1'b1, periph_addr(4'(POWER_MANAGER_IDX), PM_STATUS), {29'b0, m_pm_state},
                "pm status gated");
    write_word(1'b0, periph_addr(4'(TIMER_IDX), TIMER_CTRL), 32'h1);
    wait_irq_level(1'b1, cmp + 16);
    expect_level("power_gate_core_o", power_gate_core_o, 1'b1);
    @(negedge clk_i);
    expect_level("power_gate_core_o", power_gate_core_o, 1'b0);
    expect_level("cpu_rst_o", cpu_rst_o, 1'b1);
    @(negedge clk_i);
    expect_level("power_gate_core_o", power_gate_core_o, 1'b0);
    expect_level("cpu_rst_o", cpu_rst_o, 1'b0);
    write_word(1'b1, periph_addr(4'(TIMER_IDX), TIMER_CTRL), 32'h0);
    m_pm_state = 3'd0;
    read_expect(1'b0, periph_addr(4'(POWER_MANAGER_IDX), PM_STATUS), {29'b0, m_pm_state},
                "pm status awake");
  endtask

  initial begin
    core_req_i = '0;
    dbg_req_i = '0;
    boot_select_i = 1'b0;
    rst_i = 1'b1;
    m_exit_valid = 1'b0;
    m_exit_value = '0;
    m_scratch = '0;
    m_pm_state = 3'd0;
    next_dbg = 1'b0;
    void'($urandom(32'h5e5c));
    $readmemh("verilog/boot_rom.hex", rom_model);
    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;
    expect_level("core_resp_o.rvalid", core_resp_o.rvalid, 1'b0);
    expect_level("dbg_resp_o.rvalid", dbg_resp_o.rvalid, 1'b0);
    expect_level("core_resp_o.gnt", core_resp_o.gnt, 1'b0);
    expect_level("dbg_resp_o.gnt", dbg_resp_o.gnt, 1'b0);
    expect_level("exit_valid_o", exit_valid_o, 1'b0);
    expect_level("power_gate_core_o", power_gate_core_o, 1'b0);
    expect_level("cpu_rst_o", cpu_rst_o, 1'b0);
    expect_level("timer_irq_o", timer_irq_o, 1'b0);
    contend_rom_reads(8);
    soc_traffic(60);
    rom_traffic(30);
    unmapped_traffic(20);
    check_registers_kept();
    timer_sequence();
    sleep_sequence();
    contend_rom_reads(6);
    @(negedge clk_i);
    if (dut0.assert0.fail_count != 0) begin
      $display("%0d bus handshake assertions failed", dut0.assert0.fail_count);
      stop_run();
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- testbench/ao_peripheral_subsystem_assert.sv
/* Bus handshake assertions
   Grant and response rules of both OBI ports of the AO subsystem */
`timescale 1ns/1ns
`default_nettype none

module ao_peripheral_subsystem_assert
  import obi_pkg::*;
(
  input logic      clk_i,
  input logic      rst_i,
  input obi_req_t  core_req_i,
  input obi_resp_t core_resp_i,
  input obi_req_t  dbg_req_i,
  input obi_resp_t dbg_resp_i
);

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  core_gnt_with_req: assert property (@(posedge clk_i) disable iff (rst_i)
    core_resp_i.gnt |-> core_req_i.req)
  else begin
    $error("core gnt without req");
    fail_count++;
  end

  dbg_gnt_with_req: assert property (@(posedge clk_i) disable iff (rst_i)
    dbg_resp_i.gnt |-> dbg_req_i.req)
  else begin
    $error("dbg gnt without req");
    fail_count++;
  end

  single_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    !(core_resp_i.gnt && dbg_resp_i.gnt))
  else begin
    $error("both ports granted in one cycle");
    fail_count++;
  end

  core_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    core_resp_i.gnt |=> core_resp_i.rvalid)
  else begin
    $error("core rvalid missing after gnt");
    fail_count++;
  end

  dbg_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    dbg_resp_i.gnt |=> dbg_resp_i.rvalid)
  else begin
    $error("dbg rvalid missing after gnt");
    fail_count++;
  end

  core_rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    core_resp_i.rvalid |-> $past(core_resp_i.gnt))
  else begin
    $error("core rvalid without a grant");
    fail_count++;
  end

  dbg_rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    dbg_resp_i.rvalid |-> $past(dbg_resp_i.gnt))
  else begin
    $error("dbg rvalid without a grant");
    fail_count++;
  end

endmodule

bind ao_peripheral_subsystem ao_peripheral_subsystem_assert assert0 (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .core_req_i (core_req_i),
  .core_resp_i(core_resp_o),
  .dbg_req_i  (dbg_req_i),
  .dbg_resp_i (dbg_resp_o)
);

`default_nettype wire

//--- verilog/ao_peripheral_subsystem.sv
/* Always-on peripheral subsystem
   Core and debug OBI ports share a register bus to the AO peripherals */
`timescale 1ns/1ns
`default_nettype none

module ao_peripheral_subsystem
  import obi_pkg::*;
  import ao_periph_pkg::*;
#(
  parameter int unsigned BootRomWords = 16,
  parameter int unsigned TimerWidth = 32
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  obi_req_t    core_req_i,
  output obi_resp_t   core_resp_o,
  input  obi_req_t    dbg_req_i,
  output obi_resp_t   dbg_resp_o,
  input  logic        boot_select_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o,
  output logic        power_gate_core_o,
  output logic        cpu_rst_o,
  output logic        timer_irq_o
);

  obi_req_t  arb_req;
  obi_resp_t arb_resp;
  reg_req_t  bus_req;
  reg_rsp_t  bus_rsp;
  logic      timer_irq;

  reg_req_t [AO_PERIPHERALS-1:0] periph_req;
  reg_rsp_t [AO_PERIPHERALS-1:0] periph_rsp;

  obi_arbiter obi_arbiter_i (
    .clk_i,
    .rst_i,
    .req0_i (core_req_i),
    .req1_i (dbg_req_i),
    .resp0_o(core_resp_o),
    .resp1_o(dbg_resp_o),
    .req_o  (arb_req),
    .resp_i (arb_resp)
  );

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .rst_i,
    .obi_req_i (arb_req),
    .obi_resp_o(arb_resp),
    .reg_req_o (bus_req),
    .reg_rsp_i (bus_rsp)
  );

  reg_demux reg_demux_i (
    .reg_req_i   (bus_req),
    .reg_rsp_o   (bus_rsp),
    .periph_req_o(periph_req),
    .periph_rsp_i(periph_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_i,
    .reg_req_i(periph_req[SOC_CTRL_IDX]),
    .reg_rsp_o(periph_rsp[SOC_CTRL_IDX]),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  boot_rom #(
    .BootRomWords(BootRomWords)
  ) boot_rom_i (
    .reg_req_i(periph_req[BOOT_ROM_IDX]),
    .reg_rsp_o(periph_rsp[BOOT_ROM_IDX])
  );

  power_manager power_manager_i (
    .clk_i,
    .rst_i,
    .reg_req_i (periph_req[POWER_MANAGER_IDX]),
    .reg_rsp_o (periph_rsp[POWER_MANAGER_IDX]),
    .wake_irq_i(timer_irq),
    .power_gate_core_o,
    .cpu_rst_o
  );

  ao_timer #(
    .TimerWidth(TimerWidth)
  ) ao_timer_i (
    .clk_i,
    .rst_i,
    .reg_req_i(periph_req[TIMER_IDX]),
    .reg_rsp_o(periph_rsp[TIMER_IDX]),
    .irq_o    (timer_irq)
  );

  assign timer_irq_o = timer_irq;

endmodule

`default_nettype wire

//--- verilog/ao_timer.sv
/* Always-on timer
   Prescaled up-counter with a level compare interrupt */
`timescale 1ns/1ns
`default_nettype none

module ao_timer
  import obi_pkg::*;
  import ao_periph_pkg::*;
#(
  parameter int unsigned TimerWidth = 32
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output logic     irq_o
);

  logic                  enable_q;
  logic [TimerWidth-1:0] prescale_q;
  logic [TimerWidth-1:0] presc_cnt_q;
  logic [TimerWidth-1:0] count_q;
  logic [TimerWidth-1:0] compare_q;
  logic                  irq_q;
  logic                  wr_en;
  logic [7:0]            offset;
  logic [31:0]           wdata;
  logic [3:0]            wstrb;

  assign wr_en = reg_req_i.valid & reg_req_i.write;
  assign offset = reg_req_i.addr[7:0];
  assign wdata = reg_req_i.wdata;
  assign wstrb = reg_req_i.wstrb;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q <= 1'b0;
      prescale_q <= '0;
      presc_cnt_q <= '0;
      count_q <= '0;
      compare_q <= '0;
      irq_q <= 1'b0;
    end else begin
      if (!enable_q) begin
        presc_cnt_q <= '0;
      end else if (presc_cnt_q == prescale_q) begin
        presc_cnt_q <= '0;
        count_q <= count_q + 1'b1;
      end else begin
        presc_cnt_q <= presc_cnt_q + 1'b1;
      end
      // Register writes win over the increment
      if (wr_en) begin
        case (offset)
          TIMER_CTRL: begin
            if (wstrb[0]) begin
              enable_q <= wdata[0];
            end
          end
          TIMER_PRESCALE: prescale_q <= TimerWidth'(apply_wstrb(32'(prescale_q), wdata, wstrb));
          TIMER_COUNT:    count_q <= TimerWidth'(apply_wstrb(32'(count_q), wdata, wstrb));
          TIMER_COMPARE:  compare_q <= TimerWidth'(apply_wstrb(32'(compare_q), wdata, wstrb));
          default: ;
        endcase
      end
      irq_q <= enable_q & (count_q >= compare_q);
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (offset)
      TIMER_CTRL:     reg_rsp_o.rdata = {31'b0, enable_q};
      TIMER_PRESCALE: reg_rsp_o.rdata = 32'(prescale_q);
      TIMER_COUNT:    reg_rsp_o.rdata = 32'(count_q);
      TIMER_COMPARE:  reg_rsp_o.rdata = 32'(compare_q);
      default:        reg_rsp_o.rdata = '0;
    endcase
  end

  assign irq_o = irq_q;

endmodule

`default_nettype wire

//--- verilog/power_manager.sv
/* Power manager
   Holds the core in reset and power gating until a timer wake-up */
`timescale 1ns/1ns
`default_nettype none

module power_manager
  import obi_pkg::*;
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  input  logic     wake_irq_i,
  output logic     power_gate_core_o,
  output logic     cpu_rst_o
);

  typedef enum logic [2:0] {
    PM_ACTIVE  = 3'd0,
    PM_RESET   = 3'd1,
    PM_GATED   = 3'd2,
    PM_UNGATE  = 3'd3,
    PM_RELEASE = 3'd4
  } pm_state_e;

  pm_state_e state_q;
  logic      sleep_req;

  assign sleep_req = reg_req_i.valid & reg_req_i.write & (reg_req_i.addr[7:0] == PM_CTRL) &
                     reg_req_i.wstrb[0] & reg_req_i.wdata[0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= PM_ACTIVE;
    end else begin
      case (state_q)
        PM_ACTIVE: begin
          if (sleep_req) begin
            state_q <= PM_RESET;
          end
        end
        PM_RESET: state_q <= PM_GATED;
        PM_GATED: begin
          // Wait for the timer
          if (wake_irq_i) begin
            state_q <= PM_UNGATE;
          end
        end
        PM_UNGATE:  state_q <= PM_RELEASE;
        default:    state_q <= PM_ACTIVE;
      endcase
    end
  end

  assign cpu_rst_o = (state_q == PM_RESET) || (state_q == PM_GATED) || (state_q == PM_UNGATE);
  assign power_gate_core_o = (state_q == PM_GATED);

  always_comb begin
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    if (reg_req_i.addr[7:0] == PM_STATUS) begin
      reg_rsp_o.rdata = {29'b0, state_q};
    end
  end

endmodule

`default_nettype wire

//--- verilog/boot_rom.sv
/* Boot ROM
   Word-addressed read-only memory filled from a hex image */
`timescale 1ns/1ns
`default_nettype none

module boot_rom
  import obi_pkg::*;
#(
  parameter int unsigned BootRomWords = 16
) (
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o
);

  localparam int unsigned AddrBits = $clog2(BootRomWords);

  logic [31:0]         rom_mem [BootRomWords];
  logic [AddrBits-1:0] word_idx;

  initial begin
    $readmemh("verilog/boot_rom.hex", rom_mem);
  end

  // Wraps modulo the ROM size
  assign word_idx = reg_req_i.addr[AddrBits+1:2];

  assign reg_rsp_o.rdata = rom_mem[word_idx];
  assign reg_rsp_o.error = reg_req_i.valid & reg_req_i.write;

endmodule

`default_nettype wire

//--- verilog/soc_ctrl.sv
/* SoC control registers
   Exit status, boot select and a scratch word */
`timescale 1ns/1ns
`default_nettype none

module soc_ctrl
  import obi_pkg::*;
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  input  logic        boot_select_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] scratch_q;
  logic        wr_en;
  logic [7:0]  offset;

  assign wr_en = reg_req_i.valid & reg_req_i.write;
  assign offset = reg_req_i.addr[7:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q <= '0;
    end else if (wr_en) begin
      if (offset == SOC_EXIT_VALID && reg_req_i.wstrb[0]) begin
        exit_valid_q <= reg_req_i.wdata[0];
      end
      if (offset == SOC_EXIT_VALUE) begin
        exit_value_q <= apply_wstrb(exit_value_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (offset == SOC_SCRATCH) begin
        scratch_q <= apply_wstrb(scratch_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (offset)
      SOC_EXIT_VALID:  reg_rsp_o.rdata = {31'b0, exit_valid_q};
      SOC_EXIT_VALUE:  reg_rsp_o.rdata = exit_value_q;
      SOC_BOOT_SELECT: reg_rsp_o.rdata = {31'b0, boot_select_i};
      SOC_SCRATCH:     reg_rsp_o.rdata = scratch_q;
      default:         reg_rsp_o.rdata = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

`default_nettype wire

//--- verilog/reg_demux.sv
/* Register bus demultiplexer
   Routes an access to one peripheral and flags unmapped indices */
`timescale 1ns/1ns
`default_nettype none

module reg_demux
  import obi_pkg::*;
  import ao_periph_pkg::*;
(
  input  reg_req_t                      reg_req_i,
  output reg_rsp_t                      reg_rsp_o,
  output reg_req_t [AO_PERIPHERALS-1:0] periph_req_o,
  input  reg_rsp_t [AO_PERIPHERALS-1:0] periph_rsp_i
);

  logic [3:0]                  periph_idx;
  logic [PERIPH_SEL_WIDTH-1:0] periph_sel;
  logic                        in_range;

  assign periph_idx = reg_req_i.addr[11:8];
  assign periph_sel = periph_idx[PERIPH_SEL_WIDTH-1:0];
  assign in_range = (periph_idx < 4'(AO_PERIPHERALS));

  // Only the selected port sees valid
  always_comb begin
    for (int i = 0; i < AO_PERIPHERALS; i++) begin
      periph_req_o[i] = reg_req_i;
      periph_req_o[i].valid = reg_req_i.valid & in_range &
                              (periph_sel == PERIPH_SEL_WIDTH'(i));
    end
  end

  always_comb begin
    if (in_range) begin
      reg_rsp_o = periph_rsp_i[periph_sel];
    end else begin
      // Decode error
      reg_rsp_o.rdata = '0;
      reg_rsp_o.error = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/obi_to_reg.sv
/* OBI to register bus converter
   Grants each request at once and returns the response one cycle later */
`timescale 1ns/1ns
`default_nettype none

module obi_to_reg
  import obi_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  obi_req_t  obi_req_i,
  output obi_resp_t obi_resp_o,
  output reg_req_t  reg_req_o,
  input  reg_rsp_t  reg_rsp_i
);

  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  always_comb begin
    reg_req_o.valid = obi_req_i.req;
    reg_req_o.write = obi_req_i.we;
    reg_req_o.wstrb = obi_req_i.be;
    reg_req_o.addr = obi_req_i.addr;
    reg_req_o.wdata = obi_req_i.wdata;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
    end
  end

  // Response data of the granted access
  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q <= reg_rsp_i.rdata;
      err_q <= reg_rsp_i.error;
    end
  end

  always_comb begin
    obi_resp_o.gnt = obi_req_i.req;
    obi_resp_o.rvalid = rvalid_q;
    obi_resp_o.err = err_q;
    obi_resp_o.rdata = rdata_q;
  end

endmodule

`default_nettype wire

//--- verilog/obi_arbiter.sv
/* Round-robin arbiter for two OBI masters
   Forwards the winning request and routes the response back to it */
`timescale 1ns/1ns
`default_nettype none

module obi_arbiter
  import obi_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  obi_req_t  req0_i,
  input  obi_req_t  req1_i,
  output obi_resp_t resp0_o,
  output obi_resp_t resp1_o,
  output obi_req_t  req_o,
  input  obi_resp_t resp_i
);

  logic sel;
  logic prio1_q;
  logic rsp_sel_q;

  // Port 1 wins alone or when it holds priority
  always_comb begin
    if (req0_i.req && req1_i.req) begin
      sel = prio1_q;
    end else begin
      sel = req1_i.req;
    end
  end

  assign req_o = sel ? req1_i : req0_i;

  always_comb begin
    resp0_o = '0;
    resp1_o = '0;
    resp0_o.gnt = resp_i.gnt & ~sel;
    resp1_o.gnt = resp_i.gnt & sel;
    if (resp_i.rvalid) begin
      if (rsp_sel_q) begin
        resp1_o.rvalid = 1'b1;
        resp1_o.err = resp_i.err;
        resp1_o.rdata = resp_i.rdata;
      end else begin
        resp0_o.rvalid = 1'b1;
        resp0_o.err = resp_i.err;
        resp0_o.rdata = resp_i.rdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio1_q <= 1'b0;
      rsp_sel_q <= 1'b0;
    end else if (resp_i.gnt) begin
      prio1_q <= ~sel;
      rsp_sel_q <= sel;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ao_periph_pkg.sv
/* Always-on peripheral map
   Peripheral indices and register offsets of the subsystem */
`default_nettype none

package ao_periph_pkg;

  localparam int unsigned AO_PERIPHERALS = 4;
  localparam int unsigned PERIPH_SEL_WIDTH = 2;

  // Index taken from address bits 11:8
  localparam int unsigned SOC_CTRL_IDX = 0;
  localparam int unsigned BOOT_ROM_IDX = 1;
  localparam int unsigned POWER_MANAGER_IDX = 2;
  localparam int unsigned TIMER_IDX = 3;

  // SoC control
  localparam logic [7:0] SOC_EXIT_VALID = 8'h00;
  localparam logic [7:0] SOC_EXIT_VALUE = 8'h04;
  localparam logic [7:0] SOC_BOOT_SELECT = 8'h08;
  localparam logic [7:0] SOC_SCRATCH = 8'h0C;

  // Power manager
  localparam logic [7:0] PM_CTRL = 8'h00;
  localparam logic [7:0] PM_STATUS = 8'h04;

  // Timer
  localparam logic [7:0] TIMER_CTRL = 8'h00;
  localparam logic [7:0] TIMER_PRESCALE = 8'h04;
  localparam logic [7:0] TIMER_COUNT = 8'h08;
  localparam logic [7:0] TIMER_COMPARE = 8'h0C;

endpackage

`default_nettype wire

//--- verilog/obi_pkg.sv
/* OBI bus types
   Request and response of the OBI ports and of the internal register bus */
`default_nettype none

package obi_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  // Byte-wise merge of a register write
  function automatic logic [31:0] apply_wstrb(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire
